// ==== hw/rab_cfg_pkg.sv ====
`default_nettype none

package rab_cfg_pkg;

   // ************************************************************
   // bus and register file geometry
   // ************************************************************

   localparam int data_width    = 32;
   localparam int strb_width    = data_width / 8;
   localparam int addr_width    = 32;
   localparam int reg_entries   = 32;
   localparam int reg_idx_msb   = $clog2(reg_entries) + 1;   // index is addr[6:2]
   localparam int reg_idx_width = reg_idx_msb - 1;

   localparam int n_ports = 2;   // l2 tlb ports

   // window 0 is the register file, window j+1 is tlb port j
   localparam logic [addr_width-1:0] l2_window_size = 32'h0000_4000;

   localparam logic [1:0] resp_okay = 2'b00;

   // one accepted write, as seen after both channels have been taken
   typedef struct packed {
      logic                  en;     // single cycle strobe
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } wr_cmd_t;

   // write port toward one second level tlb
   typedef struct packed {
      logic                  wren;
      logic [addr_width-1:0] addr;   // word index inside the window
      logic [data_width-1:0] data;
   } tlb_wr_t;

   typedef logic [reg_entries-1:0][data_width-1:0] cfg_array_t;

endpackage

`default_nettype wire

// ==== hw/axil_write_slave.sv ====
`default_nettype none

module axil_write_slave
(
   input  wire logic                                 s_axi_aclk,
   input  wire logic                                 s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]   s_axi_awaddr,
   input  wire logic                                 s_axi_awvalid,
   output logic                                      s_axi_awready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]   s_axi_wdata,
   input  wire logic [rab_cfg_pkg::strb_width-1:0]   s_axi_wstrb,
   input  wire logic                                 s_axi_wvalid,
   output logic                                      s_axi_wready,
   output logic [1:0]                                s_axi_bresp,
   output logic                                      s_axi_bvalid,
   input  wire logic                                 s_axi_bready,
   output rab_cfg_pkg::wr_cmd_t                      wr_cmd
);

   logic                                 awaddr_done;
   logic                                 wdata_done;
   logic                                 both_done;
   logic                                 both_done_dly;
   logic                                 wresp_done;
   logic                                 wresp_running;
   logic [rab_cfg_pkg::addr_width-1:0]   waddr_reg;
   logic [rab_cfg_pkg::data_width-1:0]   wdata_reg;
   logic [rab_cfg_pkg::strb_width-1:0]   wstrb_reg;

   assign both_done = awaddr_done & wdata_done;

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
         both_done_dly <= 1'b0;
      else
         both_done_dly <= both_done;
   end

   // ************************************************************
   // address and data channels
   // ************************************************************

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b1;
         awaddr_done   <= 1'b0;
      end
      else if (s_axi_awready && s_axi_awvalid)
      begin
         s_axi_awready <= 1'b0;
         awaddr_done   <= 1'b1;
      end
      else if (awaddr_done && wresp_done)   // free after bready
      begin
         s_axi_awready <= 1'b1;
         awaddr_done   <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_wready <= 1'b1;
         wdata_done   <= 1'b0;
      end
      else if (s_axi_wready && s_axi_wvalid)
      begin
         s_axi_wready <= 1'b0;
         wdata_done   <= 1'b1;
      end
      else if (wdata_done && wresp_done)
      begin
         s_axi_wready <= 1'b1;
         wdata_done   <= 1'b0;
      end
   end

   // payload follows the handshakes
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_awready && s_axi_awvalid)
         waddr_reg <= s_axi_awaddr;
      if (s_axi_wready && s_axi_wvalid)
      begin
         wdata_reg <= s_axi_wdata;
         wstrb_reg <= s_axi_wstrb;
      end
   end

   // ************************************************************
   // response channel
   // ************************************************************

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_bvalid  <= 1'b0;
         wresp_done    <= 1'b0;
         wresp_running <= 1'b0;
      end
      else if (both_done && !wresp_done)
      begin
         if (!wresp_running)
         begin
            s_axi_bvalid  <= 1'b1;
            wresp_running <= 1'b1;
         end
         else if (s_axi_bready)
         begin
            s_axi_bvalid  <= 1'b0;
            wresp_done    <= 1'b1;
            wresp_running <= 1'b0;
         end
      end
      else
      begin
         s_axi_bvalid  <= 1'b0;   // idle or channels releasing
         wresp_done    <= 1'b0;
         wresp_running <= 1'b0;
      end
   end

   assign s_axi_bresp = rab_cfg_pkg::resp_okay;

   // first cycle with both address and data held
   assign wr_cmd = '{en:   both_done & ~both_done_dly,
                     addr: waddr_reg,
                     data: wdata_reg,
                     strb: wstrb_reg};

endmodule

`default_nettype wire

// ==== hw/axil_read_slave.sv ====
`default_nettype none

module axil_read_slave
(
   input  wire logic                                    s_axi_aclk,
   input  wire logic                                    s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]      s_axi_araddr,
   input  wire logic                                    s_axi_arvalid,
   output logic                                         s_axi_arready,
   output logic [rab_cfg_pkg::data_width-1:0]           s_axi_rdata,
   output logic [1:0]                                   s_axi_rresp,
   output logic                                         s_axi_rvalid,
   input  wire logic                                    s_axi_rready,
   output logic [rab_cfg_pkg::reg_idx_width-1:0]        rd_idx,
   input  wire logic [rab_cfg_pkg::data_width-1:0]      rd_data
);

   logic                                 araddr_done;
   logic                                 rresp_done;
   logic                                 rresp_running;
   logic [rab_cfg_pkg::addr_width-1:0]   raddr_reg;

   // ************************************************************
   // read address channel
   // ************************************************************

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b1;
         araddr_done   <= 1'b0;
      end
      else if (s_axi_arready && s_axi_arvalid)
      begin
         s_axi_arready <= 1'b0;
         araddr_done   <= 1'b1;
      end
      else if (araddr_done && rresp_done)
      begin
         s_axi_arready <= 1'b1;
         araddr_done   <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_arready && s_axi_arvalid)
         raddr_reg <= s_axi_araddr;
   end

   // read response, held until rready
   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_rvalid  <= 1'b0;
         rresp_done    <= 1'b0;
         rresp_running <= 1'b0;
      end
      else if (araddr_done && !rresp_done)
      begin
         if (!rresp_running)
         begin
            s_axi_rvalid  <= 1'b1;
            rresp_running <= 1'b1;
         end
         else if (s_axi_rready)
         begin
            s_axi_rvalid  <= 1'b0;
            rresp_done    <= 1'b1;
            rresp_running <= 1'b0;
         end
      end
      else
      begin
         s_axi_rvalid  <= 1'b0;
         rresp_done    <= 1'b0;
         rresp_running <= 1'b0;
      end
   end

   assign rd_idx      = raddr_reg[rab_cfg_pkg::reg_idx_msb:2];   // window aliasing
   assign s_axi_rdata = rd_data;
   assign s_axi_rresp = rab_cfg_pkg::resp_okay;

endmodule

`default_nettype wire

// ==== hw/rab_cfg_regfile.sv ====
`default_nettype none

module rab_cfg_regfile
(
   input  wire logic                                  s_axi_aclk,
   input  wire logic                                  s_axi_aresetn,
   input  wire rab_cfg_pkg::wr_cmd_t                  wr_cmd,
   input  wire logic [rab_cfg_pkg::reg_idx_width-1:0] rd_idx,
   output logic [rab_cfg_pkg::data_width-1:0]         rd_data,
   output rab_cfg_pkg::cfg_array_t                    cfg_regs
);

   logic                                     write_hit;
   logic [rab_cfg_pkg::reg_idx_width-1:0]    wr_idx;

   // only window 0 belongs to the register file
   assign write_hit = wr_cmd.en && (wr_cmd.addr < rab_cfg_pkg::l2_window_size);
   assign wr_idx    = wr_cmd.addr[rab_cfg_pkg::reg_idx_msb:2];

   // ************************************************************
   // configuration words, byte strobed
   // ************************************************************

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
         cfg_regs <= '0;
      else if (write_hit)
      begin
         for (int b = 0; b < rab_cfg_pkg::strb_width; b++)
         begin
            if (wr_cmd.strb[b])
               cfg_regs[wr_idx][b*8 +: 8] <= wr_cmd.data[b*8 +: 8];
         end
      end
   end

   assign rd_data = cfg_regs[rd_idx];   // no read latency

endmodule

`default_nettype wire

// ==== hw/l2_tlb_write_port.sv ====
`default_nettype none

module l2_tlb_write_port
(
   input  wire logic                                          s_axi_aclk,
   input  wire logic                                          s_axi_aresetn,
   input  wire rab_cfg_pkg::wr_cmd_t                          wr_cmd,
   output rab_cfg_pkg::tlb_wr_t [rab_cfg_pkg::n_ports-1:0]    tlb_l2
);

   // ************************************************************
   // one write port per l2 tlb
   // ************************************************************

   for (genvar j = 0; j < rab_cfg_pkg::n_ports; j++)
   begin : g_port
      localparam logic [rab_cfg_pkg::addr_width-1:0] win_lo =
         rab_cfg_pkg::addr_width'((j + 1) * rab_cfg_pkg::l2_window_size);
      localparam logic [rab_cfg_pkg::addr_width-1:0] win_hi =
         rab_cfg_pkg::addr_width'((j + 2) * rab_cfg_pkg::l2_window_size);

      logic                                 in_window;
      logic                                 wren_q;
      logic [rab_cfg_pkg::data_width-1:0]   data_q;

      assign in_window = (wr_cmd.addr >= win_lo) && (wr_cmd.addr < win_hi);

      always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
      begin
         if (!s_axi_aresetn)
         begin
            wren_q <= 1'b0;
            data_q <= '0;
         end
         else
         begin
            wren_q <= wr_cmd.en && in_window;   // one cycle pulse
            if (wr_cmd.en)
            begin
               // merged on every write, any window
               for (int b = 0; b < rab_cfg_pkg::strb_width; b++)
               begin
                  if (wr_cmd.strb[b])
                     data_q[b*8 +: 8] <= wr_cmd.data[b*8 +: 8];
               end
            end
         end
      end

      assign tlb_l2[j] = '{wren: wren_q,
                           addr: (wr_cmd.addr - win_lo) >> 2,
                           data: data_q};
   end

endmodule

`default_nettype wire

// ==== hw/axi_regs_top_rab.sv ====
`default_nettype none

module axi_regs_top_rab
(
   input  wire logic                                          s_axi_aclk,
   input  wire logic                                          s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]            s_axi_awaddr,
   input  wire logic                                          s_axi_awvalid,
   output logic                                               s_axi_awready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]            s_axi_wdata,
   input  wire logic [rab_cfg_pkg::strb_width-1:0]            s_axi_wstrb,
   input  wire logic                                          s_axi_wvalid,
   output logic                                               s_axi_wready,
   output logic [1:0]                                         s_axi_bresp,
   output logic                                               s_axi_bvalid,
   input  wire logic                                          s_axi_bready,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]            s_axi_araddr,
   input  wire logic                                          s_axi_arvalid,
   output logic                                               s_axi_arready,
   output logic [rab_cfg_pkg::data_width-1:0]                 s_axi_rdata,
   output logic [1:0]                                         s_axi_rresp,
   output logic                                               s_axi_rvalid,
   input  wire logic                                          s_axi_rready,
   output rab_cfg_pkg::cfg_array_t                            cfg_regs,
   output rab_cfg_pkg::tlb_wr_t [rab_cfg_pkg::n_ports-1:0]    tlb_l2
);

   rab_cfg_pkg::wr_cmd_t                     wr_cmd;
   logic [rab_cfg_pkg::reg_idx_width-1:0]    rd_idx;
   logic [rab_cfg_pkg::data_width-1:0]       rd_data;

   // ************************************************************
   // axi-lite front end
   // ************************************************************

   axil_write_slave i_axil_write_slave
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .wr_cmd        (wr_cmd)
   );

   axil_read_slave i_axil_read_slave
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .rd_idx        (rd_idx),
      .rd_data       (rd_data)
   );

   // register file and tlb forwarding share the write command
   rab_cfg_regfile i_rab_cfg_regfile
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_cmd        (wr_cmd),
      .rd_idx        (rd_idx),
      .rd_data       (rd_data),
      .cfg_regs      (cfg_regs)
   );

   l2_tlb_write_port i_l2_tlb_write_port
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_cmd        (wr_cmd),
      .tlb_l2        (tlb_l2)
   );

endmodule

`default_nettype wire

// ==== sim/rab_cfg_checker.sv ====
`default_nettype none

module rab_cfg_checker
(
   input  wire logic                                          s_axi_aclk,
   input  wire logic                                          s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]            s_axi_awaddr,
   input  wire logic                                          s_axi_awvalid,
   input  wire logic                                          s_axi_awready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]            s_axi_wdata,
   input  wire logic [rab_cfg_pkg::strb_width-1:0]            s_axi_wstrb,
   input  wire logic                                          s_axi_wvalid,
   input  wire logic                                          s_axi_wready,
   input  wire logic [1:0]                                    s_axi_bresp,
   input  wire logic                                          s_axi_bvalid,
   input  wire logic                                          s_axi_bready,
   input  wire logic [rab_cfg_pkg::addr_width-1:0]            s_axi_araddr,
   input  wire logic                                          s_axi_arvalid,
   input  wire logic                                          s_axi_arready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]            s_axi_rdata,
   input  wire logic [1:0]                                    s_axi_rresp,
   input  wire logic                                          s_axi_rvalid,
   input  wire logic                                          s_axi_rready,
   input  wire rab_cfg_pkg::cfg_array_t                       cfg_regs,
   input  wire rab_cfg_pkg::tlb_wr_t [rab_cfg_pkg::n_ports-1:0] tlb_l2,
   input  wire logic [rab_cfg_pkg::data_width-1:0]            exp_rdata,
   output int                                                 value_errs,
   output int                                                 proto_errs
);

   rab_cfg_pkg::cfg_array_t                                 ref_cfg;
   logic [rab_cfg_pkg::n_ports-1:0][rab_cfg_pkg::data_width-1:0] ref_tlb;
   logic        aw_got;
   logic        w_got;
   logic        wr_applied;
   logic        r_got;
   logic [31:0] aw_addr;
   logic [31:0] w_data;
   logic [3:0]  w_strb;
   logic [31:0] r_exp;
   logic [31:0] hit_off;
   int          hit_port;
   int          wr_stage;
   int          r_stage;
   logic        b_prev;
   logic        bready_prev;
   logic        r_prev;
   logic        rready_prev;
   logic        after_reset;

   initial
   begin
      value_errs = 0;
      proto_errs = 0;
   end

   task automatic record_mismatch(input string msg);
      value_errs++;
      $display("Fail %0t: %s", $time, msg);
   endtask

   task automatic note_violation(input string msg);
      proto_errs++;
      $display("Protocol error at time %0t: %s", $time, msg);
   endtask

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic compare_cfg();
      for (int i = 0; i < rab_cfg_pkg::reg_entries; i++)
      begin
         if (cfg_regs[i] !== ref_cfg[i])
            record_mismatch($sformatf("cfg_regs[%0d] is %h, expected %h", i, cfg_regs[i],
                                      ref_cfg[i]));
      end
   endtask

   // ************************************************************
   // reference model, sampled on the rising edge
   // ************************************************************

   always @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ref_cfg     = '0;
         ref_tlb     = '0;
         aw_got      = 0;
         w_got       = 0;
         wr_applied  = 0;
         r_got       = 0;
         wr_stage    = 0;
         r_stage     = 0;
         hit_port    = -1;
         b_prev      = 0;
         r_prev      = 0;
         after_reset = 1;
      end
      else
      begin
         if (after_reset)   // values held since reset
         begin
            if (!s_axi_awready || !s_axi_wready || !s_axi_arready)
               record_mismatch("ready low after reset");
            if (s_axi_bvalid || s_axi_rvalid)
               record_mismatch("response valid high after reset");
            for (int j = 0; j < rab_cfg_pkg::n_ports; j++)
            begin
               if (tlb_l2[j].wren !== 1'b0 || tlb_l2[j].data !== '0)
                  record_mismatch($sformatf("tlb port %0d not cleared by reset", j));
            end
            after_reset = 0;
         end
         if (wr_stage == 0)
            compare_cfg();
         for (int j = 0; j < rab_cfg_pkg::n_ports; j++)
         begin
            if (tlb_l2[j].wren !== (wr_stage == 2 && hit_port == j))
               record_mismatch($sformatf("tlb port %0d wren is %b", j, tlb_l2[j].wren));
         end
         if (wr_stage == 2)   // first bvalid cycle
         begin
            if (!s_axi_bvalid)
               record_mismatch("bvalid not high one cycle after the write command");
            compare_cfg();
            for (int j = 0; j < rab_cfg_pkg::n_ports; j++)
            begin
               if (tlb_l2[j].data !== ref_tlb[j])
                  record_mismatch($sformatf("tlb port %0d data is %h, expected %h", j,
                                            tlb_l2[j].data, ref_tlb[j]));
            end
            if (hit_port >= 0 && tlb_l2[hit_port].addr !== hit_off)
               record_mismatch($sformatf("tlb port %0d addr is %h, expected %h", hit_port,
                                         tlb_l2[hit_port].addr, hit_off));
            wr_stage = 0;
         end
         else if (wr_stage == 1)
            wr_stage = 2;

         if (s_axi_bvalid && s_axi_bresp !== rab_cfg_pkg::resp_okay)
            record_mismatch("bresp is not OKAY");
         if (s_axi_rvalid && s_axi_rresp !== rab_cfg_pkg::resp_okay)
            record_mismatch("rresp is not OKAY");
         if (s_axi_rvalid && s_axi_rdata !== r_exp)
            record_mismatch($sformatf("rdata is %h, model holds %h", s_axi_rdata, r_exp));
         if (s_axi_rvalid && s_axi_rdata !== exp_rdata)
            record_mismatch($sformatf("rdata is %h, trace expects %h", s_axi_rdata,
                                      exp_rdata));
         if (r_stage == 2)
         begin
            if (!s_axi_rvalid)
               record_mismatch("rvalid not high one cycle after the read address");
            r_stage = 0;
         end
         else if (r_stage == 1)
            r_stage = 2;

         // protocol rules
         if (b_prev && !bready_prev && !s_axi_bvalid)
            note_violation("bvalid dropped without a handshake");
         if (r_prev && !rready_prev && !s_axi_rvalid)
            note_violation("rvalid dropped without a handshake");
         if (aw_got && s_axi_awready)
            note_violation("awready came back before the write response completed");
         if (w_got && s_axi_wready)
            note_violation("wready came back before the write response completed");
         if (r_got && s_axi_arready)
            note_violation("arready came back before the read response completed");

         if (s_axi_awvalid && s_axi_awready)
         begin
            aw_got  = 1;
            aw_addr = s_axi_awaddr;
         end
         if (s_axi_wvalid && s_axi_wready)
         begin
            w_got  = 1;
            w_data = s_axi_wdata;
            w_strb = s_axi_wstrb;
         end
         if (aw_got && w_got && !wr_applied)
         begin
            hit_port = -1;
            if (aw_addr < 32'h4000)
               ref_cfg[aw_addr[6:2]] = merge_bytes(ref_cfg[aw_addr[6:2]], w_data, w_strb);
            for (int j = 0; j < rab_cfg_pkg::n_ports; j++)
            begin
               ref_tlb[j] = merge_bytes(ref_tlb[j], w_data, w_strb);   // every port
               if (aw_addr >= (j + 1) * 32'h4000 && aw_addr < (j + 2) * 32'h4000)
               begin
                  hit_port = j;
                  hit_off  = (aw_addr - (j + 1) * 32'h4000) >> 2;
               end
            end
            wr_applied = 1;
            wr_stage   = 1;
         end
         if (s_axi_bvalid && s_axi_bready)
         begin
            if (!wr_applied)
               note_violation("write response without a complete write");
            aw_got     = 0;
            w_got      = 0;
            wr_applied = 0;
         end
         if (s_axi_arvalid && s_axi_arready)
         begin
            r_got   = 1;
            r_exp   = ref_cfg[s_axi_araddr[6:2]];
            r_stage = 1;
         end
         if (s_axi_rvalid && s_axi_rready)
            r_got = 0;
         b_prev      = s_axi_bvalid;
         bready_prev = s_axi_bready;
         r_prev      = s_axi_rvalid;
         rready_prev = s_axi_rready;
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_axi_regs_top_rab.sv ====
`default_nettype none

module tb_axi_regs_top_rab;

   logic        s_axi_aclk;
   logic        s_axi_aresetn;
   logic [31:0] s_axi_awaddr;
   logic        s_axi_awvalid;
   logic        s_axi_awready;
   logic [31:0] s_axi_wdata;
   logic [3:0]  s_axi_wstrb;
   logic        s_axi_wvalid;
   logic        s_axi_wready;
   logic [1:0]  s_axi_bresp;
   logic        s_axi_bvalid;
   logic        s_axi_bready;
   logic [31:0] s_axi_araddr;
   logic        s_axi_arvalid;
   logic        s_axi_arready;
   logic [31:0] s_axi_rdata;
   logic [1:0]  s_axi_rresp;
   logic        s_axi_rvalid;
   logic        s_axi_rready;
   logic [31:0] exp_rdata;
   int          value_errs;
   int          proto_errs;
   int          cycles;
   int          cycle_limit;
   logic [15:0] lfsr;

   rab_cfg_pkg::cfg_array_t                              cfg_regs;
   rab_cfg_pkg::tlb_wr_t [rab_cfg_pkg::n_ports-1:0]      tlb_l2;

   // trace columns
   logic [31:0] q_op[$];
   logic [31:0] q_ord[$];
   logic [31:0] q_addr[$];
   logic [31:0] q_data[$];
   logic [31:0] q_strb[$];
   logic [31:0] q_exp[$];

   axi_regs_top_rab i_axi_regs_top_rab (.*);

   rab_cfg_checker i_rab_cfg_checker (.*);

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #50 s_axi_aclk = ~s_axi_aclk;
   end

   // ************************************************************
   // watchdog and stall source
   // ************************************************************

   initial
   begin
      cycles = 0;
   end

   always @(posedge s_axi_aclk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Errors found");
         $finish;
      end
   end

   function automatic logic [15:0] step_lfsr(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic int take_stall();
      logic [1:0] n;
      lfsr = step_lfsr(lfsr);
      n[0] = lfsr[0];
      lfsr = step_lfsr(lfsr);
      n[1] = lfsr[0];
      return int'(n);
   endfunction

   task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int order);
      logic aw_done;
      logic w_done;
      int   stall;
      aw_done       = 0;
      w_done        = 0;
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_awvalid = (order != 1);
      s_axi_wvalid  = (order != 0);
      while (!(aw_done && w_done))
      begin
         @(posedge s_axi_aclk);
         if (s_axi_awvalid && s_axi_awready)
            aw_done = 1;
         if (s_axi_wvalid && s_axi_wready)
            w_done = 1;
         @(negedge s_axi_aclk);
         if (aw_done)
            s_axi_awvalid = 0;
         if (w_done)
            s_axi_wvalid = 0;
         if (order == 0 && aw_done && !w_done)
            s_axi_wvalid = 1;
         if (order == 1 && w_done && !aw_done)
            s_axi_awvalid = 1;
      end
      stall = take_stall();
      repeat (stall) @(negedge s_axi_aclk);
      s_axi_bready = 1;
      do
         @(posedge s_axi_aclk);
      while (!s_axi_bvalid);
      @(negedge s_axi_aclk);
      s_axi_bready = 0;
   endtask

   task automatic read_word(input logic [31:0] addr, input logic [31:0] expected);
      int stall;
      s_axi_araddr  = addr;
      exp_rdata     = expected;
      s_axi_arvalid = 1;
      do
         @(posedge s_axi_aclk);
      while (!s_axi_arready);
      @(negedge s_axi_aclk);
      s_axi_arvalid = 0;
      stall = take_stall();
      repeat (stall) @(negedge s_axi_aclk);
      s_axi_rready = 1;
      do
         @(posedge s_axi_aclk);
      while (!s_axi_rvalid);
      @(negedge s_axi_aclk);
      s_axi_rready = 0;
   endtask

   // ************************************************************
   // main sequence
   // ************************************************************

   initial
   begin
      int          fd;
      string       line;
      logic [31:0] f[6];
      s_axi_aresetn = 0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 0;
      s_axi_bready  = 0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 0;
      s_axi_rready  = 0;
      exp_rdata     = '0;
      lfsr          = 16'd64;
      cycle_limit   = 50;

      fd = $fopen("sim/rab_cfg_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the trace file sim/rab_cfg_trace.txt");
         $display("Errors found");
         $finish;
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]) == 6)
            begin
               q_op.push_back(f[0]);
               q_ord.push_back(f[1]);
               q_addr.push_back(f[2]);
               q_data.push_back(f[3]);
               q_strb.push_back(f[4]);
               q_exp.push_back(f[5]);
            end
         end
         $fclose(fd);
         cycle_limit = 20 * q_op.size() + 50;

         repeat (5) @(posedge s_axi_aclk);
         @(negedge s_axi_aclk);
         s_axi_aresetn = 1;

         foreach (q_op[i])
         begin
            if (q_op[i] == 0)
               write_word(q_addr[i], q_data[i], q_strb[i][3:0], int'(q_ord[i]));
            else
               read_word(q_addr[i], q_exp[i]);
         end
         repeat (3) @(negedge s_axi_aclk);

         $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
         if (value_errs + proto_errs == 0)
            $display("No errors");
         else
            $display("Errors found");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== rab_cfg.f ====
hw/rab_cfg_pkg.sv
hw/axil_write_slave.sv
hw/axil_read_slave.sv
hw/rab_cfg_regfile.sv
hw/l2_tlb_write_port.sv
hw/axi_regs_top_rab.sv
sim/rab_cfg_checker.sv
sim/tb_axi_regs_top_rab.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_axi_regs_top_rab
FILELIST  = rab_cfg.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/rab_cfg_trace.txt ====
# op (0 write, 1 read)  order (0 addr first, 1 data first, 2 together)
# addr  data  strb  expected read data (hex)
0 0 00000000 11223344 f 00000000
1 0 00000000 00000000 0 11223344
0 1 00000004 a5a5a5a5 f 00000000
1 0 00000004 00000000 0 a5a5a5a5
0 2 0000007c deadbeef f 00000000
1 0 0000007c 00000000 0 deadbeef
1 0 000000fc 00000000 0 deadbeef
0 0 00000084 cafef00d f 00000000
1 0 00000004 00000000 0 cafef00d
0 1 00000000 000000ff 1 00000000
1 0 00000000 00000000 0 112233ff
0 2 00000000 99000000 8 00000000
1 0 00000000 00000000 0 992233ff
0 0 00000008 12345678 6 00000000
1 0 00000008 00000000 0 00345600
0 0 00004010 0badf00d f 00000000
1 0 00000010 00000000 0 00000000
0 1 00008020 55aa0000 c 00000000
0 2 00007ffc 01020304 f 00000000
1 0 00000000 00000000 0 992233ff
0 0 0000c000 ffffffff f 00000000
1 0 0000007c 00000000 0 deadbeef
0 2 00003f88 00770000 4 00000000
1 0 00000008 00000000 0 00775600
